//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;

    typedef enum logic [2:0] {
        state_fetch,
        state_decode,
        state_exec,
        state_mem,
        state_writeback
    } core_state_t;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        alu_op_t                   alu_op;
        logic [xlen-1:0]           imm;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rd;
        logic                      use_imm;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      branch;
        logic                      branch_ne;
        logic                      jump;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]           alu_result;
        logic [xlen-1:0]           store_data;
        logic [reg_addr_width-1:0] rd;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      take_branch;
        logic [xlen-1:0]           branch_target;
    } exec_result_t;

    typedef struct packed {
        logic [reg_addr_width-1:0] rd;
        logic                      reg_write;
        logic [xlen-1:0]           write_data;
        logic                      take_branch;
        logic [xlen-1:0]           branch_target;
    } wb_t;

    // Program load strobe with addr as a word index
    typedef struct packed {
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } imem_load_t;

    typedef struct packed {
        logic                      valid;
        logic [xlen-1:0]           pc;
        logic [reg_addr_width-1:0] rd;
        logic                      reg_write;
        logic [xlen-1:0]           write_data;
    } retire_t;

endpackage

`default_nettype wire

//--- hw/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch #(
    parameter int imem_words = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pkg::core_state_t     state,
    input  logic [core_pkg::xlen-1:0] pc,
    input  core_pkg::imem_load_t      imem_load,
    output logic [core_pkg::xlen-1:0] instr
);

    localparam int idx_width = $clog2(imem_words);

    // addi x0, x0, 0
    localparam logic [core_pkg::xlen-1:0] nop_word = 32'h0000_0013;

    logic [core_pkg::xlen-1:0] imem [imem_words];
    logic [idx_width-1:0]      fetch_idx;
    logic [idx_width-1:0]      load_idx;

    assign fetch_idx = pc[idx_width+1:2];
    assign load_idx  = imem_load.addr[idx_width-1:0];

    // Load port is live whatever the state
    always_ff @(posedge clk) begin
        if (imem_load.we) begin
            imem[load_idx] <= imem_load.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= nop_word;
        end else if (state == core_pkg::state_fetch) begin
            instr <= imem[fetch_idx];
        end
    end

endmodule

`default_nettype wire

//--- hw/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pkg::core_state_t     state,
    input  logic [core_pkg::xlen-1:0] instr,
    output core_pkg::ctrl_t           ctrl
);

    core_pkg::opcode_t opcode;
    core_pkg::ctrl_t   ctrl_next;
    logic [2:0]        funct3;
    logic              funct7_b5;

    logic [core_pkg::xlen-1:0] imm_i;
    logic [core_pkg::xlen-1:0] imm_s;
    logic [core_pkg::xlen-1:0] imm_b;
    logic [core_pkg::xlen-1:0] imm_u;
    logic [core_pkg::xlen-1:0] imm_j;

    assign opcode    = core_pkg::opcode_t'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Shared funct3 mapping for register and immediate ALU forms
    function automatic core_pkg::alu_op_t alu_from_funct(input logic [2:0] f3,
                                                         input logic sub);
        core_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = sub ? core_pkg::alu_sub : core_pkg::alu_add;
            3'b010:  op = core_pkg::alu_slt;
            3'b100:  op = core_pkg::alu_xor;
            3'b110:  op = core_pkg::alu_or;
            3'b111:  op = core_pkg::alu_and;
            default: op = core_pkg::alu_add;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl_next        = '0;
        ctrl_next.alu_op = core_pkg::alu_add;
        ctrl_next.rs1    = instr[19:15];
        ctrl_next.rs2    = instr[24:20];
        ctrl_next.rd     = instr[11:7];
        case (opcode)
            core_pkg::op_lui: begin
                ctrl_next.alu_op    = core_pkg::alu_pass_b;
                ctrl_next.imm       = imm_u;
                ctrl_next.use_imm   = 1'b1;
                ctrl_next.reg_write = 1'b1;
            end
            core_pkg::op_imm: begin
                ctrl_next.alu_op    = alu_from_funct(funct3, 1'b0);
                ctrl_next.imm       = imm_i;
                ctrl_next.use_imm   = 1'b1;
                ctrl_next.reg_write = 1'b1;
            end
            core_pkg::op_reg: begin
                ctrl_next.alu_op    = alu_from_funct(funct3, funct7_b5);
                ctrl_next.reg_write = 1'b1;
            end
            core_pkg::op_load: begin
                ctrl_next.imm       = imm_i;
                ctrl_next.use_imm   = 1'b1;
                ctrl_next.reg_write = 1'b1;
                ctrl_next.mem_read  = 1'b1;
            end
            core_pkg::op_store: begin
                ctrl_next.imm       = imm_s;
                ctrl_next.use_imm   = 1'b1;
                ctrl_next.mem_write = 1'b1;
            end
            core_pkg::op_branch: begin
                ctrl_next.imm       = imm_b;
                // Only beq and bne
                ctrl_next.branch    = (funct3[2:1] == 2'b00);
                ctrl_next.branch_ne = funct3[0];
            end
            core_pkg::op_jal: begin
                ctrl_next.imm       = imm_j;
                ctrl_next.reg_write = 1'b1;
                ctrl_next.jump      = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (state == core_pkg::state_decode) begin
            ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                we,
    input  logic [core_pkg::reg_addr_width-1:0] rs1,
    input  logic [core_pkg::reg_addr_width-1:0] rs2,
    input  logic [core_pkg::reg_addr_width-1:0] rd,
    input  logic [core_pkg::xlen-1:0]           write_data,
    output logic [core_pkg::xlen-1:0]           rs1_data,
    output logic [core_pkg::xlen-1:0]           rs2_data
);

    localparam int num_regs = 2 ** core_pkg::reg_addr_width;

    logic [core_pkg::xlen-1:0] regs [num_regs];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= write_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- hw/exec.sv
`timescale 1ns/1ps
`default_nettype none

module exec (
    input  logic                      clk,
    input  logic                      rst_n,
    input  core_pkg::core_state_t     state,
    input  logic [core_pkg::xlen-1:0] pc,
    input  core_pkg::ctrl_t           ctrl,
    input  logic [core_pkg::xlen-1:0] rs1_data,
    input  logic [core_pkg::xlen-1:0] rs2_data,
    output core_pkg::exec_result_t    ex
);

    logic [core_pkg::xlen-1:0] operand_b;
    logic [core_pkg::xlen-1:0] alu_out;
    logic                      operands_equal;
    logic                      take_branch;
    core_pkg::exec_result_t    ex_next;

    assign operand_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::alu_add:    alu_out = rs1_data + operand_b;
            core_pkg::alu_sub:    alu_out = rs1_data - operand_b;
            core_pkg::alu_and:    alu_out = rs1_data & operand_b;
            core_pkg::alu_or:     alu_out = rs1_data | operand_b;
            core_pkg::alu_xor:    alu_out = rs1_data ^ operand_b;
            core_pkg::alu_slt: begin
                alu_out = {{(core_pkg::xlen-1){1'b0}},
                           ($signed(rs1_data) < $signed(operand_b))};
            end
            core_pkg::alu_pass_b: alu_out = operand_b;
            default:              alu_out = '0;
        endcase
    end

    // Branch compare always uses the register pair
    assign operands_equal = (rs1_data == rs2_data);
    assign take_branch    = ctrl.jump |
                            (ctrl.branch & (ctrl.branch_ne ? ~operands_equal : operands_equal));

    always_comb begin
        ex_next.alu_result    = ctrl.jump ? pc + 32'd4 : alu_out;
        ex_next.store_data    = rs2_data;
        ex_next.rd            = ctrl.rd;
        ex_next.reg_write     = ctrl.reg_write;
        ex_next.mem_read      = ctrl.mem_read;
        ex_next.mem_write     = ctrl.mem_write;
        ex_next.take_branch   = take_branch;
        ex_next.branch_target = pc + ctrl.imm;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex <= '0;
        end else if (state == core_pkg::state_exec) begin
            ex <= ex_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem.sv
`timescale 1ns/1ps
`default_nettype none

module mem #(
    parameter int dmem_words = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::core_state_t  state,
    input  core_pkg::exec_result_t ex,
    output core_pkg::wb_t          wb
);

    localparam int idx_width = $clog2(dmem_words);

    logic [core_pkg::xlen-1:0] dmem [dmem_words];
    logic [idx_width-1:0]      word_idx;
    logic [core_pkg::xlen-1:0] read_word;
    logic                      in_mem_state;

    assign word_idx     = ex.alu_result[idx_width+1:2];
    assign read_word    = dmem[word_idx];
    assign in_mem_state = (state == core_pkg::state_mem);

    always_ff @(posedge clk) begin
        if (in_mem_state && ex.mem_write) begin
            dmem[word_idx] <= ex.store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (in_mem_state) begin
            wb.rd            <= ex.rd;
            wb.reg_write     <= ex.reg_write;
            wb.write_data    <= ex.mem_read ? read_word : ex.alu_result;
            wb.take_branch   <= ex.take_branch;
            wb.branch_target <= ex.branch_target;
        end
    end

endmodule

`default_nettype wire

//--- hw/core.sv
`timescale 1ns/1ps
`default_nettype none

module core #(
    parameter int imem_words = 64,
    parameter int dmem_words = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    input  core_pkg::imem_load_t imem_load,
    output core_pkg::retire_t    retire
);

    core_pkg::core_state_t     state;
    core_pkg::core_state_t     state_next;
    logic [core_pkg::xlen-1:0] pc;

    logic [core_pkg::xlen-1:0] instr;
    core_pkg::ctrl_t           ctrl;
    logic [core_pkg::xlen-1:0] rs1_data;
    logic [core_pkg::xlen-1:0] rs2_data;
    core_pkg::exec_result_t    ex;
    core_pkg::wb_t             wb;
    logic                      in_writeback;
    logic                      rf_we;

    // Five fixed steps per instruction with a hold in fetch while run is low
    always_comb begin
        case (state)
            core_pkg::state_fetch:     state_next = run ? core_pkg::state_decode
                                                        : core_pkg::state_fetch;
            core_pkg::state_decode:    state_next = core_pkg::state_exec;
            core_pkg::state_exec:      state_next = core_pkg::state_mem;
            core_pkg::state_mem:       state_next = core_pkg::state_writeback;
            core_pkg::state_writeback: state_next = core_pkg::state_fetch;
            default:                   state_next = core_pkg::state_fetch;
        endcase
    end

    assign in_writeback = (state == core_pkg::state_writeback);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= core_pkg::state_fetch;
            pc    <= '0;
        end else begin
            state <= state_next;
            if (in_writeback) begin
                pc <= wb.take_branch ? wb.branch_target : pc + 32'd4;
            end
        end
    end

    assign rf_we = in_writeback && wb.reg_write;

    assign retire.valid      = in_writeback;
    assign retire.pc         = pc;
    assign retire.rd         = wb.rd;
    assign retire.reg_write  = wb.reg_write;
    assign retire.write_data = wb.write_data;

    fetch #(
        .imem_words(imem_words)
    ) fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .pc        (pc),
        .imem_load (imem_load),
        .instr     (instr)
    );

    decode decode_i (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .instr (instr),
        .ctrl  (ctrl)
    );

    register_file register_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .we         (rf_we),
        .rs1        (ctrl.rs1),
        .rs2        (ctrl.rs2),
        .rd         (wb.rd),
        .write_data (wb.write_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    exec exec_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .pc       (pc),
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex       (ex)
    );

    mem #(
        .dmem_words(dmem_words)
    ) mem_i (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .ex    (ex),
        .wb    (wb)
    );

endmodule

`default_nettype wire

//--- verif/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int max_steps = 32;
    localparam int retire_timeout = 20;
    localparam int retire_spacing = 5;

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    logic                 clk;
    logic                 rst_n;
    logic                 run;
    core_pkg::imem_load_t imem_load;
    core_pkg::retire_t    retire;

    // Program table, one row per instruction word in memory order
    logic [31:0]       instr_tab [max_steps];
    core_pkg::retire_t expect_tab [max_steps];
    bit                retires_tab [max_steps];
    string             name_tab [max_steps];
    int                num_steps = 0;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    core #(
        .imem_words(64),
        .dmem_words(64)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .imem_load (imem_load),
        .retire    (retire)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] encode_i(input logic [31:0] imm, input logic [31:0] rs1,
                                             input logic [2:0] f3, input logic [31:0] rd,
                                             input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [31:0] rs2,
                                             input logic [31:0] rs1, input logic [2:0] f3,
                                             input logic [31:0] rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_reg};
    endfunction

    function automatic logic [31:0] encode_s(input logic [31:0] imm, input logic [31:0] rs2,
                                             input logic [31:0] rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] encode_b(input logic [31:0] imm, input logic [31:0] rs2,
                                             input logic [31:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] encode_u(input logic [31:0] upper, input logic [31:0] rd);
        return {upper[19:0], rd[4:0], opc_lui};
    endfunction

    function automatic logic [31:0] encode_j(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
    endfunction

    task automatic add_step(input string name, input logic [31:0] word, input bit retires,
                            input logic [31:0] pc, input logic [31:0] rd, input bit we,
                            input logic [31:0] data);
        core_pkg::retire_t expected;
        expected.valid      = 1'b1;
        expected.pc         = pc;
        expected.rd         = rd[4:0];
        expected.reg_write  = we;
        expected.write_data = data;
        instr_tab[num_steps]   = word;
        expect_tab[num_steps]  = expected;
        retires_tab[num_steps] = retires;
        name_tab[num_steps]    = name;
        num_steps++;
    endtask

    task automatic build_program();
        add_step("addi_x1", encode_i(5, 0, 3'b000, 1, opc_imm), 1'b1, 0, 1, 1'b1, 32'h5);
        add_step("addi_neg", encode_i(-3, 0, 3'b000, 2, opc_imm), 1'b1, 4, 2, 1'b1, 32'hffff_fffd);
        add_step("add", encode_r(7'h00, 2, 1, 3'b000, 3), 1'b1, 8, 3, 1'b1, 32'h2);
        add_step("sub", encode_r(7'h20, 2, 1, 3'b000, 4), 1'b1, 12, 4, 1'b1, 32'h8);
        add_step("and", encode_r(7'h00, 2, 1, 3'b111, 5), 1'b1, 16, 5, 1'b1, 32'h5);
        add_step("or", encode_r(7'h00, 2, 1, 3'b110, 6), 1'b1, 20, 6, 1'b1, 32'hffff_fffd);
        add_step("xor", encode_r(7'h00, 2, 1, 3'b100, 7), 1'b1, 24, 7, 1'b1, 32'hffff_fff8);
        add_step("slt_true", encode_r(7'h00, 1, 2, 3'b010, 8), 1'b1, 28, 8, 1'b1, 32'h1);
        add_step("slt_false", encode_r(7'h00, 2, 1, 3'b010, 9), 1'b1, 32, 9, 1'b1, 32'h0);
        add_step("lui", encode_u(32'h12345, 10), 1'b1, 36, 10, 1'b1, 32'h1234_5000);
        add_step("ori", encode_i(32'h0f0, 1, 3'b110, 11, opc_imm), 1'b1, 40, 11, 1'b1, 32'hf5);
        add_step("andi", encode_i(32'h0ff, 2, 3'b111, 12, opc_imm), 1'b1, 44, 12, 1'b1, 32'hfd);
        add_step("xori", encode_i(-1, 1, 3'b100, 13, opc_imm), 1'b1, 48, 13, 1'b1, 32'hffff_fffa);
        add_step("sw", encode_s(8, 10, 0), 1'b1, 52, 0, 1'b0, 32'h0);
        add_step("lw", encode_i(8, 0, 3'b010, 14, opc_load), 1'b1, 56, 14, 1'b1, 32'h1234_5000);
        add_step("beq_taken", encode_b(8, 1, 1, 3'b000), 1'b1, 60, 0, 1'b0, 32'h0);
        add_step("beq_shadow", encode_i(1, 0, 3'b000, 15, opc_imm), 1'b0, 64, 15, 1'b1, 32'h1);
        add_step("bne_fall", encode_b(8, 1, 1, 3'b001), 1'b1, 68, 0, 1'b0, 32'h0);
        add_step("jal", encode_j(8, 16), 1'b1, 72, 16, 1'b1, 32'd76);
        add_step("jal_shadow", encode_i(7, 0, 3'b000, 17, opc_imm), 1'b0, 76, 17, 1'b1, 32'h7);
        add_step("addi_x0", encode_i(9, 0, 3'b000, 0, opc_imm), 1'b1, 80, 0, 1'b1, 32'h9);
        add_step("add_x0", encode_r(7'h00, 1, 0, 3'b000, 18), 1'b1, 84, 18, 1'b1, 32'h5);
    endtask

    // rd and write_data only matter when the instruction writes a register
    task automatic check_retire(input string name, input core_pkg::retire_t expected,
                                input core_pkg::retire_t actual);
        logic mismatch;
        checks++;
        mismatch = (actual.pc !== expected.pc) || (actual.reg_write !== expected.reg_write);
        if (expected.reg_write) begin
            mismatch = mismatch || (actual.rd !== expected.rd) ||
                       (actual.write_data !== expected.write_data);
        end
        if (mismatch) begin
            errors++;
            $write("[FAIL] %s: expected pc=%h rd=%0d we=%b data=%h, ",
                   name, expected.pc, expected.rd, expected.reg_write, expected.write_data);
            $display("actual pc=%h rd=%0d we=%b data=%h",
                     actual.pc, actual.rd, actual.reg_write, actual.write_data);
        end
    endtask

    task automatic check_gap(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %s retire spacing: expected %0d cycles, actual %0d",
                     name, expected, actual);
        end
    endtask

    task automatic wait_retire(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < retire_timeout; n++) begin
            @(negedge clk);
            if (retire.valid) begin
                seen = 1'b1;
                break;
            end
        end
    endtask

    initial begin
        bit seen;
        int last_cycle;
        clk        = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_load  = '0;
        last_cycle = -1;
        build_program();

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int i = 0; i < num_steps; i++) begin
            @(posedge clk);
            #1;
            imem_load.we   = 1'b1;
            imem_load.addr = i;
            imem_load.data = instr_tab[i];
        end
        @(posedge clk);
        #1 imem_load = '0;

        // Core must stay idle in fetch while run is low
        for (int n = 0; n < 10; n++) begin
            @(negedge clk);
            if (retire.valid) begin
                errors++;
                $display("an instruction retired while run was low");
            end
        end

        @(posedge clk);
        #1 run = 1'b1;

        for (int i = 0; i < num_steps; i++) begin
            if (!retires_tab[i]) begin
                continue;
            end
            wait_retire(seen);
            if (!seen) begin
                errors++;
                $display("no retire for step %s within %0d cycles",
                         name_tab[i], retire_timeout);
                break;
            end
            check_retire(name_tab[i], expect_tab[i], retire);
            if (last_cycle >= 0) begin
                check_gap(name_tab[i], retire_spacing, cycle_count - last_cycle);
            end
            last_cycle = cycle_count;
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/core_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/register_file.sv
hw/exec.sv
hw/mem.sv
hw/core.sv
verif/core_tb.sv

//--- Makefile
TOP := core_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module core -f verilog.f

clean:
	rm -rf obj_dir $(LOG)
